//--- src/rv32_defines.svh
// RV32 pipeline sizing constants and the canonical bubble encoding

`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// Data path and pc width
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// Register index width
`define RV_REG_W 5

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

//--- src/rv32_pkg.sv
// RV32 pipeline types: instruction views, control word and stage buffers

`include "rv32_defines.svh"

package rv32_pkg;

    typedef logic [`RV_XLEN-1:0] rv32_word;
    typedef logic [`RV_REG_W-1:0] rv_reg_id_t;

    // Major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        rv_reg_id_t rs2;
        rv_reg_id_t rs1;
        logic [2:0] funct3;
        rv_reg_id_t rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        rv_reg_id_t  rs1;
        logic [2:0]  funct3;
        rv_reg_id_t  rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed {
        logic [19:0] imm;
        rv_reg_id_t  rd;
        opcode_t     opcode;
    } u_type_t;

    // One instruction word, seen through each format
    typedef union packed {
        logic [31:0] raw;
        r_type_t     r;
        i_type_t     i;
        u_type_t     u;
    } rv32_instr_u;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL,
        ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS_B, ALU_MUL
    } alu_op_t;

    // Operand source: register read or execute buffer result
    typedef enum logic {
        NONE,
        FROM_EXEC
    } bypass_t;

    typedef struct packed {
        alu_op_t    alu_op;
        logic       use_imm;
        rv32_word   imm;
        rv_reg_id_t rd;
        logic       reg_write;
        logic       is_mul;
        bypass_t    bypass_rs1;
        bypass_t    bypass_rs2;
    } decoded_instr_t;

    typedef struct packed {
        rv32_word    pc;
        rv32_instr_u instr;
    } fetch_buffer_data_t;

    typedef struct packed {
        rv32_word       pc;
        rv32_instr_u    instr;
        rv32_word       reg1;
        rv32_word       reg2;
        decoded_instr_t decoded_instr;
    } decoded_buffer_data_t;

    typedef struct packed {
        rv32_word   pc;
        rv_reg_id_t rd;
        logic       reg_write;
        logic       is_mul;
        rv32_word   result;
    } exec_buffer_data_t;

    // Control word of a bubble, writes nothing
    function automatic decoded_instr_t create_nop_ctrl();
        decoded_instr_t ctrl;
        ctrl.alu_op     = ALU_ADD;
        ctrl.use_imm    = 1'b1;
        ctrl.imm        = '0;
        ctrl.rd         = '0;
        ctrl.reg_write  = 1'b0;
        ctrl.is_mul     = 1'b0;
        ctrl.bypass_rs1 = NONE;
        ctrl.bypass_rs2 = NONE;
        return ctrl;
    endfunction

endpackage

//--- src/rv32_regfile_if.sv
// Register file read path between the decode stage and the register file

`timescale 1ns/100ps

interface rv32_regfile_if import rv32_pkg::*; ();

    // Read addresses
    rv_reg_id_t rs1;
    rv_reg_id_t rs2;

    // Read data, same cycle
    rv32_word reg1;
    rv32_word reg2;

    modport decode (output rs1, output rs2, input reg1, input reg2);

    modport regfile (input rs1, input rs2, output reg1, output reg2);

endinterface

//--- src/rv32_regfile.sv
// Integer register file, two write-through read ports and one write port

`timescale 1ns/100ps

`include "rv32_defines.svh"

module rv32_regfile import rv32_pkg::*; (
    input logic            clk,
    input logic            resetn,
    rv32_regfile_if.regfile rf,
    input logic            we,
    input rv_reg_id_t      wd_rd,
    input rv32_word        wd
);

    // x0 has no storage
    rv32_word regs [1:`RV_NREGS-1];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_rd != '0) begin
            regs[wd_rd] <= wd;
        end
    end

    // Same-cycle write wins over the stored value
    always_comb begin
        if (rf.rs1 == '0) begin
            rf.reg1 = '0;
        end else if (we && wd_rd == rf.rs1) begin
            rf.reg1 = wd;
        end else begin
            rf.reg1 = regs[rf.rs1];
        end
    end

    always_comb begin
        if (rf.rs2 == '0) begin
            rf.reg2 = '0;
        end else if (we && wd_rd == rf.rs2) begin
            rf.reg2 = wd;
        end else begin
            rf.reg2 = regs[rf.rs2];
        end
    end

endmodule

//--- src/rv32_decoder.sv
// Instruction decoder for OP, OP-IMM, LUI and MUL

`timescale 1ns/100ps

module rv32_decoder import rv32_pkg::*; (
    input  rv32_instr_u    instr,
    output decoded_instr_t decoded_instr,
    output logic [1:0]     use_rs
);

    always_comb begin
        decoded_instr = create_nop_ctrl();
        use_rs = 2'b00;

        case (instr.r.opcode)
            OPC_OP: begin
                decoded_instr.rd        = instr.r.rd;
                decoded_instr.reg_write = 1'b1;
                decoded_instr.use_imm   = 1'b0;
                use_rs = 2'b11;
                if (instr.r.funct7 == 7'b0000001) begin
                    // Only MUL from the M extension, other funct3 become bubbles
                    if (instr.r.funct3 == 3'b000) begin
                        decoded_instr.alu_op = ALU_MUL;
                        decoded_instr.is_mul = 1'b1;
                    end else begin
                        decoded_instr = create_nop_ctrl();
                        use_rs = 2'b00;
                    end
                end else begin
                    case (instr.r.funct3)
                        3'b000:  decoded_instr.alu_op = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
                        3'b001:  decoded_instr.alu_op = ALU_SLL;
                        3'b010:  decoded_instr.alu_op = ALU_SLT;
                        3'b011:  decoded_instr.alu_op = ALU_SLTU;
                        3'b100:  decoded_instr.alu_op = ALU_XOR;
                        3'b101:  decoded_instr.alu_op = instr.r.funct7[5] ? ALU_SRA : ALU_SRL;
                        3'b110:  decoded_instr.alu_op = ALU_OR;
                        default: decoded_instr.alu_op = ALU_AND;
                    endcase
                end
            end

            OPC_OP_IMM: begin
                decoded_instr.rd        = instr.i.rd;
                decoded_instr.reg_write = 1'b1;
                decoded_instr.imm       = rv32_word'($signed(instr.i.imm));
                use_rs = 2'b01;
                // Shift amount sits in the low immediate bits
                case (instr.i.funct3)
                    3'b000:  decoded_instr.alu_op = ALU_ADD;
                    3'b001:  decoded_instr.alu_op = ALU_SLL;
                    3'b010:  decoded_instr.alu_op = ALU_SLT;
                    3'b011:  decoded_instr.alu_op = ALU_SLTU;
                    3'b100:  decoded_instr.alu_op = ALU_XOR;
                    3'b101:  decoded_instr.alu_op = instr.i.imm[10] ? ALU_SRA : ALU_SRL;
                    3'b110:  decoded_instr.alu_op = ALU_OR;
                    default: decoded_instr.alu_op = ALU_AND;
                endcase
            end

            OPC_LUI: begin
                decoded_instr.rd        = instr.u.rd;
                decoded_instr.reg_write = 1'b1;
                decoded_instr.imm       = {instr.u.imm, 12'h000};
                decoded_instr.alu_op    = ALU_PASS_B;
            end

            default: begin
                // Unknown opcode, keep the bubble
                decoded_instr = create_nop_ctrl();
            end
        endcase
    end

endmodule

//--- src/rv32_hazard_unit.sv
// Hazard detection against decode_data, bypass selects and MUL stall

`timescale 1ns/100ps

module rv32_hazard_unit import rv32_pkg::*; (
    input  logic [1:0]           use_rs,
    input  rv32_instr_u          current_instr,
    input  decoded_buffer_data_t decoded_buff,
    output logic                 stall,
    output bypass_t              bypass_rs [2]
);

    rv_reg_id_t src [2];
    rv_reg_id_t producer_rd;
    logic       producer_writes;
    logic       producer_mul;

    assign src[0] = current_instr.r.rs1;
    assign src[1] = current_instr.r.rs2;

    // Instruction one stage ahead, now in the decode register
    assign producer_rd     = decoded_buff.decoded_instr.rd;
    assign producer_writes = decoded_buff.decoded_instr.reg_write;
    assign producer_mul    = decoded_buff.decoded_instr.is_mul;

    always_comb begin
        stall = 1'b0;
        for (int k = 0; k < 2; k++) begin
            bypass_rs[k] = NONE;
            if (use_rs[k] && src[k] != '0 && producer_writes && src[k] == producer_rd) begin
                // Product is not on the bypass path
                if (producer_mul) begin
                    stall = 1'b1;
                end else begin
                    bypass_rs[k] = FROM_EXEC;
                end
            end
        end
    end

endmodule

//--- src/rv32_decode_stage.sv
// Decode stage: field split, register read, hazards and decode register

`timescale 1ns/100ps

`include "rv32_defines.svh"

module rv32_decode_stage import rv32_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 set_nop,
    input  logic                 stop,
    input  rv32_word             set_nop_pc,
    input  fetch_buffer_data_t   instr_data,
    output decoded_buffer_data_t decode_data,
    output logic                 stall,
    rv32_regfile_if.decode       rf
);

    decoded_buffer_data_t next_data;
    decoded_instr_t       decoder_output;
    logic [1:0]           use_rs;
    bypass_t              bypass_rs [2];

    rv32_decoder decoder (
        .instr         (instr_data.instr),
        .decoded_instr (decoder_output),
        .use_rs        (use_rs)
    );

    rv32_hazard_unit hazard_unit (
        .use_rs        (use_rs),
        .current_instr (instr_data.instr),
        .decoded_buff  (decode_data),
        .stall         (stall),
        .bypass_rs     (bypass_rs)
    );

    assign rf.rs1 = instr_data.instr.r.rs1;
    assign rf.rs2 = instr_data.instr.r.rs2;

    always_comb begin
        next_data.pc            = instr_data.pc;
        next_data.instr         = instr_data.instr;
        next_data.reg1          = rf.reg1;
        next_data.reg2          = rf.reg2;
        next_data.decoded_instr = decoder_output;
        next_data.decoded_instr.bypass_rs1 = bypass_rs[0];
        next_data.decoded_instr.bypass_rs2 = bypass_rs[1];

        // Bubble on stall or flush, flush also redirects the pc
        if (stall || set_nop) begin
            next_data.instr.raw     = `RV_NOP;
            next_data.decoded_instr = create_nop_ctrl();
            if (set_nop) begin
                next_data.pc = set_nop_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            decode_data.pc            <= '0;
            decode_data.instr.raw     <= `RV_NOP;
            decode_data.reg1          <= '0;
            decode_data.reg2          <= '0;
            decode_data.decoded_instr <= create_nop_ctrl();
        end else if (!stop) begin
            decode_data <= next_data;
        end
    end

endmodule

//--- src/rv32_exec_stage.sv
// Execute stage: operand bypass, ALU, multiplier and execute buffer

`timescale 1ns/100ps

module rv32_exec_stage import rv32_pkg::*; (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 stop,
    input  decoded_buffer_data_t decode_data,
    output exec_buffer_data_t    exec_buff
);

    decoded_instr_t    ctrl;
    rv32_word          op_a;
    rv32_word          rs2_val;
    rv32_word          op_b;
    rv32_word          product;
    rv32_word          alu_result;
    exec_buffer_data_t next_buff;

    assign ctrl = decode_data.decoded_instr;

    // Previous result feeds back when the decode stage asked for it
    assign op_a    = (ctrl.bypass_rs1 == FROM_EXEC) ? exec_buff.result : decode_data.reg1;
    assign rs2_val = (ctrl.bypass_rs2 == FROM_EXEC) ? exec_buff.result : decode_data.reg2;
    assign op_b    = ctrl.use_imm ? ctrl.imm : rs2_val;

    // Low half of the product
    assign product = op_a * op_b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLL:    alu_result = op_a << op_b[4:0];
            ALU_SRL:    alu_result = op_a >> op_b[4:0];
            ALU_SRA:    alu_result = rv32_word'($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:    alu_result = rv32_word'($signed(op_a) < $signed(op_b));
            ALU_SLTU:   alu_result = rv32_word'(op_a < op_b);
            ALU_PASS_B: alu_result = op_b;
            ALU_MUL:    alu_result = product;
            default:    alu_result = '0;
        endcase
    end

    always_comb begin
        next_buff.pc        = decode_data.pc;
        next_buff.rd        = ctrl.rd;
        next_buff.reg_write = ctrl.reg_write;
        next_buff.is_mul    = ctrl.is_mul;
        next_buff.result    = alu_result;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exec_buff <= '0;
        end else if (!stop) begin
            exec_buff <= next_buff;
        end
    end

endmodule

//--- src/rv32_core.sv
// RV32 decode and execute pipeline top with writeback result ports

`timescale 1ns/100ps

`include "rv32_defines.svh"

module rv32_core import rv32_pkg::*; (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  stop,
    input  logic                  flush,
    input  logic [`RV_XLEN-1:0]   in_pc,
    input  logic [`RV_XLEN-1:0]   flush_pc,
    input  logic [31:0]           in_instr,
    output logic                  stall,
    output logic                  wb_valid,
    output logic [`RV_REG_W-1:0]  wb_rd,
    output logic [`RV_XLEN-1:0]   wb_data,
    output logic [`RV_XLEN-1:0]   wb_pc
);

    fetch_buffer_data_t   fetch_data;
    decoded_buffer_data_t decode_data;
    exec_buffer_data_t    exec_buff;

    rv32_regfile_if rf_if ();

    assign fetch_data.pc        = in_pc;
    assign fetch_data.instr.raw = in_instr;

    rv32_decode_stage decode_stage (
        .clk         (clk),
        .resetn      (resetn),
        .set_nop     (flush),
        .stop        (stop),
        .set_nop_pc  (flush_pc),
        .instr_data  (fetch_data),
        .decode_data (decode_data),
        .stall       (stall),
        .rf          (rf_if.decode)
    );

    rv32_exec_stage exec_stage (
        .clk         (clk),
        .resetn      (resetn),
        .stop        (stop),
        .decode_data (decode_data),
        .exec_buff   (exec_buff)
    );

    // Writeback from the execute buffer, x0 writes are dropped
    assign wb_valid = exec_buff.reg_write && (exec_buff.rd != '0) && !stop;
    assign wb_rd    = exec_buff.rd;
    assign wb_data  = exec_buff.result;
    assign wb_pc    = exec_buff.pc;

    rv32_regfile regfile (
        .clk    (clk),
        .resetn (resetn),
        .rf     (rf_if.regfile),
        .we     (wb_valid),
        .wd_rd  (exec_buff.rd),
        .wd     (exec_buff.result)
    );

endmodule

//--- tests/rv32_core_assertions.sv
// Concurrent checks on reset, stall length and x0 writeback of the pipeline top

`timescale 1ns/100ps

module rv32_core_assertions (
    input logic       clk,
    input logic       resetn,
    input logic       stop,
    input logic       stall,
    input logic       wb_valid,
    input logic [4:0] wb_rd
);

    // Count of failed assertions
    int failures = 0;

    // No hazard can exist while both buffers hold bubbles
    stall_in_reset: assert property (@(posedge clk) !resetn |-> stall == 1'b0)
        else begin
            $error("stall high during reset");
            failures++;
        end

    x0_writeback: assert property (@(posedge clk) disable iff (!resetn)
        wb_valid |-> wb_rd != 5'd0)
        else begin
            $error("writeback valid with rd of zero");
            failures++;
        end

    // The bubble inserted on a stall clears the MUL dependency
    stall_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        (stall && !stop) |=> !stall)
        else begin
            $error("stall held for more than one running cycle");
            failures++;
        end

endmodule

//--- tests/rv32_core_tb.sv
// Testbench for the RV32 decode and execute pipeline with a register model

`timescale 1ns/100ps

`include "rv32_defines.svh"

module rv32_core_tb;

    localparam logic [6:0] OP_REG = 7'b0110011;
    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;

    localparam int N_ALU   = 200;
    localparam int N_MUL   = 150;
    localparam int N_STOP  = 150;
    localparam int N_FLUSH = 150;
    localparam int N_X0    = 100;
    localparam int TOTAL_INSTR = 7 + N_ALU + 6 + N_MUL + N_STOP + N_FLUSH + N_X0;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 4 + 100;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
    } wb_entry_t;

    logic        clk;
    logic        resetn;
    logic        stop;
    logic        flush;
    logic [31:0] in_pc;
    logic [31:0] flush_pc;
    logic [31:0] in_instr;
    logic        stall;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] wb_pc;

    // Architectural model state
    logic [31:0] mregs [32];
    wb_entry_t   exp_q [$];
    logic [31:0] pc_next;

    integer seed;
    int     stop_pct;
    int     flush_pct;
    int     errors;
    int     checks;
    int     stall_count;
    int     flush_count;
    int     test_num;
    int     err_base;
    int     check_base;
    int     stall_base;
    int     idx;

    rv32_core rv32_core_i (
        .clk      (clk),
        .resetn   (resetn),
        .stop     (stop),
        .flush    (flush),
        .in_pc    (in_pc),
        .flush_pc (flush_pc),
        .in_instr (in_instr),
        .stall    (stall),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .wb_pc    (wb_pc)
    );

    bind rv32_core rv32_core_assertions core_checks (
        .clk      (clk),
        .resetn   (resetn),
        .stop     (stop),
        .stall    (stall),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the pipeline stopped making progress",
                 WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $finish;
    end

    function automatic int unsigned rnd_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
                                             input logic [4:0] rs1, input logic [2:0] f3,
                                             input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] encode_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    // Registers x0 to x7 only, so dependencies are frequent
    function automatic logic [31:0] random_instr(input bit allow_mul, input int x0_pct);
        int unsigned kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        kind = allow_mul ? rnd_below(5) : rnd_below(4);
        rd   = rnd_below(8);
        rs1  = rnd_below(8);
        rs2  = rnd_below(8);
        f3   = rnd_below(8);
        imm  = $random(seed);
        if (rnd_below(100) < x0_pct) begin
            rd = 5'd0;
        end
        case (kind)
            0, 1: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && rnd_below(2) == 1) ? 7'h20 : 7'h00;
                return encode_r(f7, rs2, rs1, f3, rd);
            end
            2: begin
                // Shifts carry the shift type above the shift amount
                if (f3 == 3'b001) begin
                    imm = {7'h00, imm[4:0]};
                end else if (f3 == 3'b101) begin
                    imm = {(rnd_below(2) == 1) ? 7'h20 : 7'h00, imm[4:0]};
                end
                return encode_i(imm, rs1, f3, rd);
            end
            3: return encode_lui($random(seed), rd);
            default: return encode_r(7'h01, rs2, rs1, 3'b000, rd);
        endcase
    endfunction

    // Executes one accepted instruction by the RV32I and M rules
    task automatic model_execute(input logic [31:0] instr, input logic [31:0] pc);
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] val;
        wb_entry_t   e;
        opc = instr[6:0];
        rd  = instr[11:7];
        f3  = instr[14:12];
        f7  = instr[31:25];
        a   = mregs[instr[19:15]];
        b   = (opc == OP_REG) ? mregs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        if (opc == OP_LUI) begin
            val = {instr[31:12], 12'h000};
        end else if (opc == OP_REG && f7 == 7'h01) begin
            val = a * b;
        end else begin
            case (f3)
                3'b000:  val = (opc == OP_REG && f7[5]) ? a - b : a + b;
                3'b001:  val = a << b[4:0];
                3'b010:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b011:  val = (a < b) ? 32'd1 : 32'd0;
                3'b100:  val = a ^ b;
                3'b101:  val = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
                3'b110:  val = a | b;
                default: val = a & b;
            endcase
        end
        if (rd != 5'd0) begin
            mregs[rd] = val;
            e.rd   = rd;
            e.data = val;
            e.pc   = pc;
            exp_q.push_back(e);
        end
    endtask

    task automatic check_writeback();
        wb_entry_t want;
        if (wb_valid === 1'b1) begin
            checks++;
            if (wb_rd == 5'd0) begin
                errors++;
                $display("Fail at %0t: writeback reported for x0", $time);
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected writeback to x%0d at %0t with nothing outstanding",
                         wb_rd, $time);
            end else begin
                want = exp_q.pop_front();
                if (wb_rd !== want.rd || wb_data !== want.data || wb_pc !== want.pc) begin
                    errors++;
                    $display("Fail at %0t: got x%0d=%h pc %h, expected x%0d=%h pc %h",
                             $time, wb_rd, wb_data, wb_pc, want.rd, want.data, want.pc);
                end
            end
        end else if (wb_valid !== 1'b0) begin
            errors++;
            $display("wb_valid is unknown at %0t", $time);
        end
    endtask

    task automatic roll_controls();
        stop     <= (rnd_below(100) < stop_pct);
        flush    <= (rnd_below(100) < flush_pct);
        flush_pc <= $random(seed);
    endtask

    // Holds the instruction until it is taken or flushed
    task automatic issue_instr(input logic [31:0] instr);
        logic        done;
        logic        take;
        logic        flushed;
        logic [31:0] pc;
        done = 1'b0;
        pc   = pc_next;
        in_instr <= instr;
        in_pc    <= pc;
        roll_controls();
        while (!done) begin
            @(negedge clk);
            check_writeback();
            if (stall) begin
                stall_count++;
            end
            take    = !stall && !stop && !flush;
            flushed = flush;
            @(posedge clk);
            if (take) begin
                model_execute(instr, pc);
                done = 1'b1;
            end else if (flushed) begin
                flush_count++;
                done = 1'b1;
            end else begin
                roll_controls();
            end
        end
        pc_next = pc_next + 32'd4;
    endtask

    task automatic drain_pipeline();
        int tail;
        tail = 0;
        in_instr <= `RV_NOP;
        stop     <= 1'b0;
        flush    <= 1'b0;
        // A few extra cycles catch stray results
        while (exp_q.size() != 0 || tail < 4) begin
            @(negedge clk);
            check_writeback();
            @(posedge clk);
            if (exp_q.size() == 0) begin
                tail++;
            end
        end
    endtask

    task automatic start_test(input int s_pct, input int f_pct);
        test_num++;
        err_base   = errors;
        check_base = checks;
        stop_pct   = s_pct;
        flush_pct  = f_pct;
    endtask

    task automatic finish_test(input string name);
        drain_pipeline();
        $display("Test %0d %s: %0d results checked, %0d errors",
                 test_num, name, checks - check_base, errors - err_base);
    endtask

    initial begin
        seed        = 35347;
        errors      = 0;
        checks      = 0;
        stall_count = 0;
        flush_count = 0;
        test_num    = 0;
        pc_next     = 32'h0000_1000;
        resetn      = 1'b0;
        stop        = 1'b0;
        flush       = 1'b1;
        in_pc       = '0;
        flush_pc    = '0;
        // Self-dependent MUL at the input would stall against a live decode register
        in_instr    = encode_r(7'h01, 5'd1, 5'd1, 3'b000, 5'd1);
        for (idx = 0; idx < 32; idx++) begin
            mregs[idx] = '0;
        end

        repeat (10) @(posedge clk);
        resetn <= 1'b1;

        // Registers read back as zero after reset
        start_test(0, 0);
        @(negedge clk);
        if (stall !== 1'b0 || wb_valid !== 1'b0) begin
            errors++;
            $display("Fail at %0t: stall %b wb_valid %b after reset", $time, stall, wb_valid);
        end
        @(posedge clk);
        for (idx = 1; idx < 8; idx++) begin
            issue_instr(encode_i(12'h000, idx[4:0], 3'b000, idx[4:0]));
        end
        finish_test("reset reads");

        start_test(0, 0);
        for (idx = 0; idx < N_ALU; idx++) begin
            issue_instr(random_instr(1'b0, 0));
        end
        finish_test("alu bypass");

        start_test(0, 0);
        stall_base = stall_count;
        issue_instr(encode_i(12'd13, 5'd0, 3'b000, 5'd1));
        issue_instr(encode_i(12'hff9, 5'd0, 3'b000, 5'd2));
        issue_instr(encode_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3));
        issue_instr(encode_r(7'h00, 5'd1, 5'd3, 3'b000, 5'd4));
        issue_instr(encode_r(7'h01, 5'd3, 5'd3, 3'b000, 5'd5));
        issue_instr(encode_i(12'd1, 5'd5, 3'b000, 5'd6));
        if (stall_count == stall_base) begin
            errors++;
            $display("Fail at %0t: no stall after MUL with a dependent instruction", $time);
        end
        for (idx = 0; idx < N_MUL; idx++) begin
            issue_instr(random_instr(1'b1, 0));
        end
        finish_test("mul stall");

        start_test(30, 0);
        for (idx = 0; idx < N_STOP; idx++) begin
            issue_instr(random_instr(1'b1, 0));
        end
        finish_test("stop");

        start_test(0, 15);
        for (idx = 0; idx < N_FLUSH; idx++) begin
            issue_instr(random_instr(1'b1, 0));
        end
        finish_test("flush");

        start_test(10, 5);
        for (idx = 0; idx < N_X0; idx++) begin
            issue_instr(random_instr(1'b1, 50));
        end
        finish_test("x0 writes");

        errors = errors + rv32_core_i.core_checks.failures;
        $display("Tests run: %0d, results checked: %0d, stalls: %0d, flushes: %0d, errors: %0d",
                 test_num, checks, stall_count, flush_count, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+src
src/rv32_pkg.sv
src/rv32_regfile_if.sv
src/rv32_regfile.sv
src/rv32_decoder.sv
src/rv32_hazard_unit.sv
src/rv32_decode_stage.sv
src/rv32_exec_stage.sv
src/rv32_core.sv
tests/rv32_core_assertions.sv
tests/rv32_core_tb.sv
